// File: hdl/rob_pkg.sv
package rob_pkg;

    // sizes
    localparam int NUM_ARCH   = 32;
    localparam int NUM_PHYS   = 64;
    localparam int ROB_DEPTH  = 16;
    localparam int NUM_CPL    = 3;                    // completion ports
    localparam int FREE_DEPTH = NUM_PHYS - NUM_ARCH;  // regs free after reset

    typedef logic [4:0]  arch_reg_t;
    typedef logic [5:0]  phys_reg_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [3:0]  rob_idx_t;
    typedef logic [6:0]  opcode_t;

    localparam opcode_t OPC_STORE = 7'b0100011; // sw class

    // one renamed instruction from upstream
    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
        pc_t       pc;
        word_t     store_data;
    } dispatch_t;

    typedef struct packed {
        phys_reg_t src1;
        phys_reg_t src2;
        phys_reg_t new_dest;
        phys_reg_t old_dest;  // mapping replaced by new_dest
        logic      has_dest;
    } rename_t;

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        word_t data;
    } completion_t;

    typedef struct packed {
        logic      valid;
        logic      is_store;
        arch_reg_t arch_dest;
        phys_reg_t old_phys;  // goes back to the free list
        word_t     value;     // result, or store data for stores
        pc_t       pc;
    } retire_t;

    typedef struct packed {
        logic      valid;
        logic      complete;
        logic      is_store;
        arch_reg_t arch_dest;
        phys_reg_t new_phys;
        phys_reg_t old_phys;
        logic      has_dest;
        word_t     value;
        pc_t       pc;
    } rob_entry_t;

endpackage

// File: hdl/rename_table.sv
`timescale 1ns/1ps

module rename_table (
    input  logic                clk,
    input  logic                rstn,
    input  rob_pkg::dispatch_t  dispatch,
    input  logic                accept,
    input  rob_pkg::phys_reg_t  free_tag,
    output rob_pkg::rename_t    rename
);

    // speculative arch -> phys map, x0 never rewritten
    rob_pkg::phys_reg_t map [rob_pkg::NUM_ARCH];

    logic has_dest;

    // stores and writes to x0 take no new register
    assign has_dest = (dispatch.dest != '0) && (dispatch.opcode != rob_pkg::OPC_STORE);

    always_comb begin
        rename.src1     = map[dispatch.src1];
        rename.src2     = map[dispatch.src2];
        rename.old_dest = map[dispatch.dest];  // current mapping, freed at retire
        rename.new_dest = free_tag;            // head of free list
        rename.has_dest = has_dest;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            // identity map out of reset
            for (int i = 0; i < rob_pkg::NUM_ARCH; i++) begin
                map[i] <= rob_pkg::phys_reg_t'(i);
            end
        end else if (accept && has_dest) begin
            map[dispatch.dest] <= free_tag;
        end
    end

endmodule

// File: hdl/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                clk,
    input  logic                rstn,
    input  logic                pop,
    output rob_pkg::phys_reg_t  free_tag,
    input  rob_pkg::retire_t    push0,
    input  rob_pkg::retire_t    push1
);

    localparam int PTR_W = $clog2(rob_pkg::FREE_DEPTH);

    rob_pkg::phys_reg_t slots [rob_pkg::FREE_DEPTH];

    logic [PTR_W-1:0] head;  // next tag handed out
    logic [PTR_W-1:0] tail;  // next free slot to fill
    logic             push0_en;
    logic             push1_en;
    logic [PTR_W-1:0] push1_ptr;

    // only retires that actually renamed a register give one back
    assign push0_en = push0.valid && !push0.is_store && (push0.arch_dest != '0);
    assign push1_en = push1.valid && !push1.is_store && (push1.arch_dest != '0);

    // second push lands behind the first when both fire
    assign push1_ptr = push0_en ? tail + PTR_W'(1) : tail;

    assign free_tag = slots[head];

    // never runs empty with at most 16 dests in flight against 32 entries
    always_ff @(posedge clk) begin
        if (!rstn) begin
            head <= '0;
            tail <= '0;  // tail wrapped onto head of a full queue
            for (int i = 0; i < rob_pkg::FREE_DEPTH; i++) begin
                slots[i] <= rob_pkg::phys_reg_t'(rob_pkg::FREE_DEPTH + i);  // phys 32..63
            end
        end else begin
            if (pop) begin
                head <= head + PTR_W'(1);
            end
            if (push0_en) begin
                slots[tail] <= push0.old_phys;
            end
            if (push1_en) begin
                slots[push1_ptr] <= push1.old_phys;
            end
            tail <= tail + PTR_W'(push0_en) + PTR_W'(push1_en);
        end
    end

endmodule

// File: hdl/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 accept,
    input  rob_pkg::dispatch_t   dispatch,
    input  rob_pkg::rename_t     rename,
    input  rob_pkg::completion_t complete [rob_pkg::NUM_CPL],
    output logic                 stall,
    output rob_pkg::phys_reg_t   cpl_tag [rob_pkg::NUM_CPL],
    output logic                 cpl_set [rob_pkg::NUM_CPL],
    output rob_pkg::retire_t     retire0,
    output rob_pkg::retire_t     retire1
);

    localparam int CNT_W = $clog2(rob_pkg::ROB_DEPTH) + 1;

    rob_pkg::rob_entry_t entries [rob_pkg::ROB_DEPTH];

    rob_pkg::rob_idx_t   head;       // oldest entry
    rob_pkg::rob_idx_t   head1;      // second oldest
    rob_pkg::rob_idx_t   tail;       // next slot to fill
    logic [CNT_W-1:0]    count;
    logic                ret0;
    logic                ret1;
    logic [1:0]          n_ret;
    rob_pkg::rob_entry_t new_entry;
    logic [rob_pkg::ROB_DEPTH-1:0] hit [rob_pkg::NUM_CPL];  // per port match vector

    // retire output from an entry
    function automatic rob_pkg::retire_t to_retire(rob_pkg::rob_entry_t e, logic v);
        rob_pkg::retire_t r;
        r.valid     = v;
        r.is_store  = e.is_store;
        r.arch_dest = e.arch_dest;
        r.old_phys  = e.old_phys;
        r.value     = e.value;
        r.pc        = e.pc;
        return r;
    endfunction

    assign stall = (count == CNT_W'(rob_pkg::ROB_DEPTH));  // all entries valid

    always_comb begin
        new_entry.valid     = 1'b1;
        new_entry.complete  = 1'b0;
        new_entry.is_store  = (dispatch.opcode == rob_pkg::OPC_STORE);
        new_entry.arch_dest = dispatch.dest;
        new_entry.new_phys  = rename.new_dest;
        new_entry.old_phys  = rename.old_dest;
        new_entry.has_dest  = rename.has_dest;
        new_entry.value     = dispatch.store_data;  // overwritten by result unless store
        new_entry.pc        = dispatch.pc;
    end

    // pc match of every completion port against all live entries
    always_comb begin
        for (int p = 0; p < rob_pkg::NUM_CPL; p++) begin
            hit[p]     = '0;
            cpl_tag[p] = '0;
            cpl_set[p] = 1'b0;
            for (int e = 0; e < rob_pkg::ROB_DEPTH; e++) begin
                if (complete[p].valid && entries[e].valid && !entries[e].complete &&
                    (entries[e].pc == complete[p].pc)) begin
                    hit[p][e]  = 1'b1;
                    cpl_tag[p] = entries[e].new_phys;
                    cpl_set[p] = entries[e].has_dest;  // stores wake nothing
                end
            end
        end
    end

    // in-order retire, second only behind the first
    assign head1 = head + rob_pkg::rob_idx_t'(1);
    assign ret0  = entries[head].valid && entries[head].complete;
    assign ret1  = ret0 && entries[head1].valid && entries[head1].complete;
    assign n_ret = {1'b0, ret0} + {1'b0, ret1};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            retire0.valid <= 1'b0;
            retire1.valid <= 1'b0;
            for (int e = 0; e < rob_pkg::ROB_DEPTH; e++) begin
                entries[e].valid    <= 1'b0;
                entries[e].complete <= 1'b0;
            end
        end else begin
            // mark complete, capture result
            for (int p = 0; p < rob_pkg::NUM_CPL; p++) begin
                for (int e = 0; e < rob_pkg::ROB_DEPTH; e++) begin
                    if (hit[p][e]) begin
                        entries[e].complete <= 1'b1;
                        if (!entries[e].is_store) begin
                            entries[e].value <= complete[p].data;
                        end
                    end
                end
            end
            // tail slot is free whenever accept is high
            if (accept) begin
                entries[tail] <= new_entry;
                tail          <= tail + rob_pkg::rob_idx_t'(1);
            end
            retire0 <= to_retire(entries[head], ret0);
            retire1 <= to_retire(entries[head1], ret1);
            if (ret0) begin
                entries[head].valid <= 1'b0;
            end
            if (ret1) begin
                entries[head1].valid <= 1'b0;
            end
            head  <= head + rob_pkg::rob_idx_t'(n_ret);
            count <= count + CNT_W'(accept) - CNT_W'(n_ret);
        end
    end

endmodule

// File: hdl/ready_scoreboard.sv
`timescale 1ns/1ps

module ready_scoreboard (
    input  logic                clk,
    input  logic                rstn,
    input  logic                clr,
    input  rob_pkg::phys_reg_t  clr_tag,
    input  logic                cpl_set [rob_pkg::NUM_CPL],
    input  rob_pkg::phys_reg_t  cpl_tag [rob_pkg::NUM_CPL],
    input  rob_pkg::phys_reg_t  src1,
    input  rob_pkg::phys_reg_t  src2,
    output logic                src1_ready,
    output logic                src2_ready
);

    logic [rob_pkg::NUM_PHYS-1:0] ready;  // one bit per phys reg

    assign src1_ready = ready[src1];
    assign src2_ready = ready[src2];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ready <= '1;  // every mapped value valid out of reset
        end else begin
            if (clr) begin
                ready[clr_tag] <= 1'b0;  // new dest not produced yet
            end
            for (int p = 0; p < rob_pkg::NUM_CPL; p++) begin
                // a fresh allocation of the same tag keeps the clear
                if (cpl_set[p] && !(clr && (cpl_tag[p] == clr_tag))) begin
                    ready[cpl_tag[p]] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/arch_regfile.sv
`timescale 1ns/1ps

module arch_regfile (
    input  logic                clk,
    input  logic                rstn,
    input  rob_pkg::retire_t    wr0,
    input  rob_pkg::retire_t    wr1,
    input  rob_pkg::arch_reg_t  raddr,
    output rob_pkg::word_t      rdata
);

    rob_pkg::word_t regs [rob_pkg::NUM_ARCH];  // committed state

    logic we0;
    logic we1;

    assign we0 = wr0.valid && !wr0.is_store && (wr0.arch_dest != '0);
    assign we1 = wr1.valid && !wr1.is_store && (wr1.arch_dest != '0);

    assign rdata = regs[raddr];  // comb read

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < rob_pkg::NUM_ARCH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0) begin
                regs[wr0.arch_dest] <= wr0.value;
            end
            if (we1) begin
                regs[wr1.arch_dest] <= wr1.value;  // younger, last write wins
            end
        end
    end

endmodule

// File: hdl/ooo_backend_top.sv
`timescale 1ns/1ps

module ooo_backend_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  rob_pkg::dispatch_t   dispatch,
    input  rob_pkg::completion_t complete [rob_pkg::NUM_CPL],
    input  rob_pkg::arch_reg_t   arch_raddr,
    output logic                 stall,
    output rob_pkg::rename_t     rename_out,
    output logic                 src1_ready,
    output logic                 src2_ready,
    output rob_pkg::retire_t     retire0,
    output rob_pkg::retire_t     retire1,
    output rob_pkg::word_t       arch_rdata
);

    logic               accept;     // dispatch taken this edge
    logic               alloc;      // accept that renames a dest
    rob_pkg::phys_reg_t free_tag;
    rob_pkg::phys_reg_t cpl_tag [rob_pkg::NUM_CPL];
    logic               cpl_set [rob_pkg::NUM_CPL];

    assign accept = dispatch.valid && !stall;
    assign alloc  = accept && rename_out.has_dest;

    rename_table u_rename_table (
        .clk      (clk),
        .rstn     (rstn),
        .dispatch (dispatch),
        .accept   (accept),
        .free_tag (free_tag),
        .rename   (rename_out)
    );

    free_list u_free_list (
        .clk      (clk),
        .rstn     (rstn),
        .pop      (alloc),
        .free_tag (free_tag),
        .push0    (retire0),
        .push1    (retire1)
    );

    reorder_buffer u_reorder_buffer (
        .clk      (clk),
        .rstn     (rstn),
        .accept   (accept),
        .dispatch (dispatch),
        .rename   (rename_out),
        .complete (complete),
        .stall    (stall),
        .cpl_tag  (cpl_tag),
        .cpl_set  (cpl_set),
        .retire0  (retire0),
        .retire1  (retire1)
    );

    // sources looked up for the instruction on the dispatch port
    ready_scoreboard u_ready_scoreboard (
        .clk        (clk),
        .rstn       (rstn),
        .clr        (alloc),
        .clr_tag    (rename_out.new_dest),
        .cpl_set    (cpl_set),
        .cpl_tag    (cpl_tag),
        .src1       (rename_out.src1),
        .src2       (rename_out.src2),
        .src1_ready (src1_ready),
        .src2_ready (src2_ready)
    );

    arch_regfile u_arch_regfile (
        .clk   (clk),
        .rstn  (rstn),
        .wr0   (retire0),
        .wr1   (retire1),
        .raddr (arch_raddr),
        .rdata (arch_rdata)
    );

endmodule

// File: sim/ooo_backend_properties.sv
`timescale 1ns/1ps

module ooo_backend_properties (
    input logic                 clk,
    input logic                 rstn,
    input logic                 stall,
    input rob_pkg::retire_t     retire0,
    input rob_pkg::retire_t     retire1,
    input rob_pkg::completion_t complete [rob_pkg::NUM_CPL]
);

    logic cpl_clash;  // two live ports on one pc

    assign cpl_clash =
        (complete[0].valid && complete[1].valid && (complete[0].pc == complete[1].pc)) ||
        (complete[0].valid && complete[2].valid && (complete[0].pc == complete[2].pc)) ||
        (complete[1].valid && complete[2].valid && (complete[1].pc == complete[2].pc));

    // second retire slot only ever behind the first
    assert property (@(posedge clk) disable iff (!rstn) retire1.valid |-> retire0.valid)
        else $error("retire1 valid while retire0 is idle");

    // reset state seen on the first sampled edge out of reset
    assert property (@(posedge clk) $rose(rstn) |-> (!stall && !retire0.valid && !retire1.valid))
        else $error("stall or retire valid set right after reset");

    assert property (@(posedge clk) disable iff (!rstn) !cpl_clash)
        else $error("two completion ports carry the same pc");

endmodule

bind ooo_backend_top ooo_backend_properties u_ooo_backend_properties (
    .clk      (clk),
    .rstn     (rstn),
    .stall    (stall),
    .retire0  (retire0),
    .retire1  (retire1),
    .complete (complete)
);

// File: sim/tb_ooo_backend.sv
`timescale 1ns/1ps

module tb_ooo_backend;

    localparam int NUM_INSTR     = 200;
    localparam int CLK_PERIOD    = 20;
    localparam int MAX_CPL_DELAY = 8;   // cycles after accept

    // one accepted instruction as the model expects it at retire
    typedef struct packed {
        rob_pkg::pc_t       pc;
        logic               is_store;
        logic               has_dest;
        rob_pkg::arch_reg_t dest;
        rob_pkg::phys_reg_t new_phys;
        rob_pkg::phys_reg_t old_phys;
        rob_pkg::word_t     value;
    } expect_t;

    typedef struct packed {
        rob_pkg::pc_t       pc;
        rob_pkg::phys_reg_t new_phys;
        logic               has_dest;
        int                 due;     // earliest completion cycle
    } pend_t;

    logic                 clk;
    logic                 rstn;
    rob_pkg::dispatch_t   dispatch;
    rob_pkg::completion_t complete [rob_pkg::NUM_CPL];
    rob_pkg::arch_reg_t   arch_raddr;
    logic                 stall;
    rob_pkg::rename_t     rename_out;
    logic                 src1_ready;
    logic                 src2_ready;
    rob_pkg::retire_t     retire0;
    rob_pkg::retire_t     retire1;
    rob_pkg::word_t       arch_rdata;

    integer               seed;
    expect_t              exp_q [$];     // in flight with oldest first
    pend_t                pend_q [$];    // waiting for an execution unit
    rob_pkg::phys_reg_t   ref_map [rob_pkg::NUM_ARCH];
    rob_pkg::phys_reg_t   ref_free [$];
    logic                 ref_ready [rob_pkg::NUM_PHYS];
    rob_pkg::word_t       ref_regs [rob_pkg::NUM_ARCH];
    int                   cycle;
    int                   n_sent;
    int                   n_retired;
    int                   n_dual;
    int                   stall_cycles;
    logic                 hold_cpl;      // execution units idle until the rob fills
    logic                 held;          // dispatch waiting out a stall

    ooo_backend_top u_ooo_backend_top (
        .clk        (clk),
        .rstn       (rstn),
        .dispatch   (dispatch),
        .complete   (complete),
        .arch_raddr (arch_raddr),
        .stall      (stall),
        .rename_out (rename_out),
        .src1_ready (src1_ready),
        .src2_ready (src2_ready),
        .retire0    (retire0),
        .retire1    (retire1),
        .arch_rdata (arch_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // result an execution unit returns for a pc
    function automatic rob_pkg::word_t result_for_pc(rob_pkg::pc_t pc);
        return (pc * 32'h9e37_79b9) ^ 32'h0bad_f00d;
    endfunction

    function automatic int unsigned rand_below(int unsigned n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic rob_pkg::dispatch_t make_instr(int idx);
        rob_pkg::dispatch_t d;
        d.valid  = 1'b1;
        d.opcode = rob_pkg::opcode_t'(rand_below(128));
        if (rand_below(5) == 0) begin
            d.opcode = rob_pkg::OPC_STORE;  // about a fifth stores
        end else if (d.opcode == rob_pkg::OPC_STORE) begin
            d.opcode = 7'h33;
        end
        d.dest       = rob_pkg::arch_reg_t'(rand_below(32));
        d.src1       = rob_pkg::arch_reg_t'(rand_below(32));
        d.src2       = rob_pkg::arch_reg_t'(rand_below(32));
        d.pc         = 32'h0000_1000 + 32'(idx) * 32'd4;  // unique and increasing
        d.store_data = rob_pkg::word_t'($random(seed));
        return d;
    endfunction

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    // compare one retire slot against the oldest model entry and then commit it
    task automatic check_retire(input string name, input rob_pkg::retire_t r);
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("%s retired an instruction that was never dispatched", name);
            stop_run();
        end
        e = exp_q.pop_front();
        check({name, ".pc"}, r.pc, e.pc);
        check({name, ".is_store"}, 32'(r.is_store), 32'(e.is_store));
        check({name, ".arch_dest"}, 32'(r.arch_dest), 32'(e.dest));
        check({name, ".old_phys"}, 32'(r.old_phys), 32'(e.old_phys));
        check({name, ".value"}, r.value, e.value);
        if (e.has_dest) begin
            ref_free.push_back(e.old_phys);  // old mapping is free again
        end
        if (!e.is_store && (e.dest != '0)) begin
            ref_regs[e.dest] = e.value;
        end
        arch_raddr = e.dest;  // read back next cycle for stores too
        n_retired++;
    endtask

    task automatic drive_dispatch();
        logic    exp_stall;
        logic    has_dest;
        expect_t e;
        pend_t   pd;
        if (!held) begin
            if ((n_sent < NUM_INSTR) && (rand_below(8) != 0)) begin
                dispatch = make_instr(n_sent);
            end else begin
                dispatch.valid = 1'b0;  // bubble
            end
        end
        #1;  // comb rename path settles
        exp_stall = (exp_q.size() == rob_pkg::ROB_DEPTH);
        check("stall", 32'(stall), 32'(exp_stall));
        if (stall) begin
            stall_cycles++;
        end
        if (stall_cycles >= 4) begin
            hold_cpl = 1'b0;  // release the execution units
        end
        held = dispatch.valid && exp_stall;
        if (dispatch.valid) begin
            has_dest = (dispatch.dest != '0) && (dispatch.opcode != rob_pkg::OPC_STORE);
            check("rename_out.src1", 32'(rename_out.src1), 32'(ref_map[dispatch.src1]));
            check("rename_out.src2", 32'(rename_out.src2), 32'(ref_map[dispatch.src2]));
            check("rename_out.old_dest", 32'(rename_out.old_dest), 32'(ref_map[dispatch.dest]));
            check("rename_out.has_dest", 32'(rename_out.has_dest), 32'(has_dest));
            if (has_dest) begin
                check("rename_out.new_dest", 32'(rename_out.new_dest), 32'(ref_free[0]));
            end
            check("src1_ready", 32'(src1_ready), 32'(ref_ready[ref_map[dispatch.src1]]));
            check("src2_ready", 32'(src2_ready), 32'(ref_ready[ref_map[dispatch.src2]]));
            if (!exp_stall) begin
                e.pc       = dispatch.pc;
                e.is_store = (dispatch.opcode == rob_pkg::OPC_STORE);
                e.has_dest = has_dest;
                e.dest     = dispatch.dest;
                e.new_phys = ref_free[0];  // model free list head
                e.old_phys = ref_map[dispatch.dest];
                e.value    = e.is_store ? dispatch.store_data : result_for_pc(dispatch.pc);
                exp_q.push_back(e);
                if (has_dest) begin
                    ref_map[dispatch.dest] = ref_free.pop_front();
                    ref_ready[ref_map[dispatch.dest]] = 1'b0;
                end
                pd.pc       = dispatch.pc;
                pd.new_phys = e.new_phys;
                pd.has_dest = has_dest;
                pd.due      = cycle + 1 + int'(rand_below(MAX_CPL_DELAY));
                pend_q.push_back(pd);
                n_sent++;
            end
        end
    endtask

    // random pick per port gives out-of-order completion
    task automatic drive_completions();
        int unsigned idx;
        for (int p = 0; p < rob_pkg::NUM_CPL; p++) begin
            complete[p] = '0;
            if (!hold_cpl && (pend_q.size() > 0)) begin
                idx = rand_below(pend_q.size());
                if (pend_q[idx].due <= cycle) begin
                    complete[p].valid = 1'b1;
                    complete[p].pc    = pend_q[idx].pc;
                    complete[p].data  = result_for_pc(pend_q[idx].pc);
                    if (pend_q[idx].has_dest) begin
                        ref_ready[pend_q[idx].new_phys] = 1'b1;
                    end
                    pend_q.delete(idx);
                end
            end
        end
    endtask

    initial begin
        seed       = 32'h1e642630;
        rstn       = 1'b0;
        dispatch   = '0;
        arch_raddr = '0;
        for (int p = 0; p < rob_pkg::NUM_CPL; p++) begin
            complete[p] = '0;
        end
        for (int i = 0; i < rob_pkg::NUM_ARCH; i++) begin
            ref_map[i]  = rob_pkg::phys_reg_t'(i);  // identity out of reset
            ref_regs[i] = '0;
        end
        for (int i = rob_pkg::NUM_ARCH; i < rob_pkg::NUM_PHYS; i++) begin
            ref_free.push_back(rob_pkg::phys_reg_t'(i));
        end
        for (int i = 0; i < rob_pkg::NUM_PHYS; i++) begin
            ref_ready[i] = 1'b1;
        end
        cycle        = 0;
        n_sent       = 0;
        n_retired    = 0;
        n_dual       = 0;
        stall_cycles = 0;
        hold_cpl     = 1'b1;
        held         = 1'b0;
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        while (n_retired < NUM_INSTR) begin
            @(negedge clk);
            cycle++;
            check("arch_rdata", arch_rdata, ref_regs[arch_raddr]);  // retire write landed
            arch_raddr = rob_pkg::arch_reg_t'(rand_below(32));
            if (retire0.valid) begin
                check_retire("retire0", retire0);
            end
            if (retire1.valid) begin
                check_retire("retire1", retire1);  // younger of the pair
                n_dual++;
            end
            drive_dispatch();
            drive_completions();
        end
        // sweep the whole committed state
        for (int i = 0; i < rob_pkg::NUM_ARCH; i++) begin
            @(negedge clk);
            arch_raddr = rob_pkg::arch_reg_t'(i);
            #1;
            check("arch_rdata", arch_rdata, ref_regs[i]);
        end
        if (n_dual == 0) begin
            $display("no cycle retired two instructions together");
            stop_run();
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    // bound on run length including reset
    initial begin
        #((NUM_INSTR * 40 + 10) * CLK_PERIOD);
        $display("timeout, the program did not finish retiring");
        stop_run();
    end

endmodule

// File: compile.f
hdl/rob_pkg.sv
hdl/rename_table.sv
hdl/free_list.sv
hdl/reorder_buffer.sv
hdl/ready_scoreboard.sv
hdl/arch_regfile.sv
hdl/ooo_backend_top.sv
sim/ooo_backend_properties.sv
sim/tb_ooo_backend.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ooo backend testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_ooo_backend -o tb_ooo_backend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_ooo_backend > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
